// File: tb.f
common/anti_theft_pkg.sv
common/sensor_if.sv
hdl/input_conditioner.sv
anti_theft/anti_theft_fsm.sv
anti_theft/time_parameters.sv
anti_theft/countdown_timer.sv
hdl/status_light.sv
hdl/fuel_pump_fsm.sv
hdl/car_security_top.sv
dv/car_security_checker.sv
dv/tb_car_security.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the car security testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_car_security \
   -o tb_car_security \
   && ./obj_dir/tb_car_security 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }
grep -q "FAIL: see errors above" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: dv/tb_car_security.sv
`timescale 1ns/100ps

module tb_car_security;
   import anti_theft_pkg::*;

   localparam int DEBOUNCE_CYCLES = 4;
   localparam int TICK_CYCLES = 20;
   localparam int NUM_TESTS = 8;
   localparam int SETTLE_CYCLES = 3 * (DEBOUNCE_CYCLES + 2);

   // expected length of all tests, longest random delay assumed
   localparam int RUN_CYCLES = 8 + 6 * TICK_CYCLES
      + (int'(DEFAULT_DRIVER_DELAY) + int'(DEFAULT_ALARM_ON) + 15 + 3) * TICK_CYCLES
      + 2 * SETTLE_CYCLES + 40 + NUM_TESTS * (DEBOUNCE_CYCLES + 10);
   localparam int TIMEOUT_CYCLES = RUN_CYCLES * 3 / 2;

   logic        clock_25mhz;
   logic        reset_sync;
   logic        ignition;
   logic        driver_door;
   logic        passenger_door;
   logic        hidden_switch;
   logic        brake;
   logic        reprogram;
   logic [1:0]  time_selector;
   logic [3:0]  time_value;
   logic        alarm;
   logic        status_led;
   logic        fuel_pump_power;

   logic        check_start;
   time_value_t check_delay;
   int          tests_done;
   int          error_count;
   int          tests_started;
   int          cycle_count = 0;

   car_security_top #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
      .TICK_CYCLES     (TICK_CYCLES)
   ) u_dut (
      .clock_25mhz     (clock_25mhz),
      .reset_sync      (reset_sync),
      .ignition        (ignition),
      .driver_door     (driver_door),
      .passenger_door  (passenger_door),
      .hidden_switch   (hidden_switch),
      .brake           (brake),
      .reprogram       (reprogram),
      .time_selector   (time_selector),
      .time_value      (time_value),
      .alarm           (alarm),
      .status_led      (status_led),
      .fuel_pump_power (fuel_pump_power)
   );

   car_security_checker #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
      .TICK_CYCLES     (TICK_CYCLES)
   ) u_checker (
      .clock_25mhz     (clock_25mhz),
      .reset_sync      (reset_sync),
      .alarm           (alarm),
      .status_led      (status_led),
      .fuel_pump_power (fuel_pump_power),
      .check_start     (check_start),
      .check_delay     (check_delay),
      .tests_done      (tests_done),
      .error_count     (error_count)
   );

   initial
   begin
      clock_25mhz = 1'b0;
      forever #20 clock_25mhz = ~clock_25mhz;
   end

   // run limit
   always @(posedge clock_25mhz)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic wait_cycles(input int count);
      repeat (count) @(posedge clock_25mhz);
   endtask

   // called on the edge that drives the stimulus, returns once the checker is done
   task automatic begin_check(input time_value_t delay);
      check_start <= 1'b1;
      check_delay <= delay;
      tests_started++;
      @(posedge clock_25mhz);
      check_start <= 1'b0;
      while (tests_done < tests_started)
         @(posedge clock_25mhz);
   endtask

   initial
   begin
      time_value_t passenger_delay;
      void'($urandom(32'h222e_3953));
      reset_sync <= 1'b1;
      ignition <= 1'b0;
      driver_door <= 1'b0;
      passenger_door <= 1'b0;
      hidden_switch <= 1'b0;
      brake <= 1'b0;
      reprogram <= 1'b0;
      time_selector <= 2'd0;
      time_value <= 4'd0;
      check_start <= 1'b0;
      check_delay <= '0;
      tests_started = 0;
      repeat (8) @(posedge clock_25mhz);
      reset_sync <= 1'b0;

      @(posedge clock_25mhz);
      begin_check('0);

      // armed, driver door opens and then closes
      @(posedge clock_25mhz);
      driver_door <= 1'b1;
      begin_check(DEFAULT_DRIVER_DELAY);
      @(posedge clock_25mhz);
      driver_door <= 1'b0;
      begin_check(DEFAULT_ALARM_ON);

      ////////////////////////////////////////////////////////////////////////////
      // new passenger delay, then the passenger door
      ////////////////////////////////////////////////////////////////////////////
      passenger_delay = time_value_t'($urandom_range(14, 1));
      @(posedge clock_25mhz);
      time_selector <= interval_passenger_delay;
      time_value <= passenger_delay;
      reprogram <= 1'b1;
      wait_cycles(SETTLE_CYCLES);
      reprogram <= 1'b0;
      wait_cycles(SETTLE_CYCLES);
      passenger_door <= 1'b1;
      begin_check(passenger_delay);

      @(posedge clock_25mhz);
      ignition <= 1'b1;
      begin_check('0);

      // fuel pump with ignition still on
      @(posedge clock_25mhz);
      begin_check('0);
      @(posedge clock_25mhz);
      hidden_switch <= 1'b1;
      brake <= 1'b1;
      begin_check('0);
      @(posedge clock_25mhz);
      ignition <= 1'b0;
      begin_check('0);

      @(posedge clock_25mhz);
      $display("tests run %0d, errors %0d", tests_done, error_count);
      if (error_count == 0 && tests_done == NUM_TESTS)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: dv/car_security_checker.sv
`timescale 1ns/100ps

module car_security_checker
#(
   parameter int DEBOUNCE_CYCLES = 4,
   parameter int TICK_CYCLES = 20
)
(
   input  logic                        clock_25mhz,
   input  logic                        reset_sync,
   input  logic                        alarm,
   input  logic                        status_led,
   input  logic                        fuel_pump_power,
   input  logic                        check_start,
   input  anti_theft_pkg::time_value_t check_delay,
   output int                          tests_done,
   output int                          error_count
);
   import anti_theft_pkg::*;

   // input register plus settle count
   localparam int DEBOUNCE_LATENCY = DEBOUNCE_CYCLES + 2;
   localparam int ALARM_WINDOW = 3;
   localparam int BLINK_WINDOW = 2;
   localparam int PUMP_WINDOW = 1;
   localparam int PUMP_HOLD_CYCLES = 40;

   int cycles;
   int test_errors;

   // cycles from the input edge until the alarm edge is seen here
   function automatic int expected_alarm_cycles(input int delay_seconds);
      // FSM transition, timer restart, expiry, alarm register, sampling
      return (delay_seconds + 1) * TICK_CYCLES + DEBOUNCE_LATENCY + 5;
   endfunction

   task automatic next_cycle();
      @(posedge clock_25mhz);
      cycles++;
   endtask

   task automatic report_mismatch(input string message);
      $display("[ERROR] %0t: %s", $time, message);
      test_errors++;
   endtask

   task automatic report_failure(input string message);
      $display("%s", message);
      test_errors++;
   endtask

   task automatic check_window(input string what, input int measured, input int expected,
                               input int window);
      if (measured < expected - window || measured > expected + window)
         report_mismatch($sformatf("%s after %0d cycles, expected %0d +/- %0d",
                                   what, measured, expected, window));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // individual checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_blink();
      logic last_led;
      logic noisy;
      int   toggles;
      int   last_toggle;
      last_led = status_led;
      noisy = 1'b0;
      toggles = 0;
      last_toggle = 0;
      while (toggles < 5 && cycles < 6 * TICK_CYCLES)
      begin
         next_cycle();
         if (alarm || fuel_pump_power)
            noisy = 1'b1;
         if (status_led != last_led)
         begin
            if (toggles > 0)
               check_window("status light toggled", cycles - last_toggle, TICK_CYCLES,
                            BLINK_WINDOW);
            toggles++;
            last_toggle = cycles;
            last_led = status_led;
         end
      end
      if (toggles < 5)
         report_failure($sformatf("status light toggled only %0d times", toggles));
      if (noisy)
         report_mismatch("alarm or fuel pump power high while idle after reset");
   endtask

   task automatic check_alarm_edge(input logic level);
      int   expected;
      logic led_dropped;
      expected = expected_alarm_cycles(int'(check_delay));
      led_dropped = 1'b0;
      while (alarm != level && cycles < expected + ALARM_WINDOW + 10)
      begin
         // steady light from the trigger onwards
         if (cycles >= DEBOUNCE_LATENCY + 2 && !status_led)
            led_dropped = 1'b1;
         next_cycle();
      end
      if (alarm != level)
         report_failure($sformatf("alarm did not %s within %0d cycles",
                                  level ? "rise" : "fall", cycles));
      else
         check_window(level ? "alarm rose" : "alarm fell", cycles, expected, ALARM_WINDOW);
      if (led_dropped)
         report_mismatch("status light went dark during the alarm sequence");
   endtask

   task automatic check_disarm();
      while ((alarm || status_led) && cycles < DEBOUNCE_LATENCY + 20)
         next_cycle();
      if (alarm || status_led)
         report_failure("ignition did not silence the alarm and status light");
      else if (cycles > DEBOUNCE_LATENCY + 2)
         report_mismatch($sformatf("alarm off after %0d cycles, limit %0d",
                                   cycles, DEBOUNCE_LATENCY + 2));
   endtask

   task automatic check_pump_edge(input logic level, input int expected);
      while (fuel_pump_power != level && cycles < expected + 20)
         next_cycle();
      if (fuel_pump_power != level)
         report_failure($sformatf("fuel pump power stuck at %0b", !level));
      else
         check_window("fuel pump power changed", cycles, expected, PUMP_WINDOW);
   endtask

   task automatic run_test(input int number);
      string name;
      logic  pump_seen;
      cycles = 1;
      test_errors = 0;
      pump_seen = 1'b0;
      case (number)
         1:
         begin
            name = "status light blinks after reset";
            check_blink();
         end
         2, 4:
         begin
            name = (number == 2) ? "driver door alarm" : "passenger door alarm";
            check_alarm_edge(1'b1);
         end
         3:
         begin
            name = "alarm stops after alarm-on time";
            check_alarm_edge(1'b0);
         end
         5:
         begin
            name = "ignition disarms";
            check_disarm();
         end
         6:
         begin
            name = "ignition alone keeps the pump off";
            repeat (PUMP_HOLD_CYCLES)
            begin
               next_cycle();
               if (fuel_pump_power)
                  pump_seen = 1'b1;
            end
            if (pump_seen)
               report_mismatch("fuel pump power rose with ignition alone");
         end
         7:
         begin
            name = "hidden switch and brake restore the pump";
            // debounce, restore state, power register, sampling
            check_pump_edge(1'b1, DEBOUNCE_LATENCY + 3);
         end
         8:
         begin
            name = "ignition off cuts the pump";
            check_pump_edge(1'b0, DEBOUNCE_LATENCY + 2);
         end
         default:
         begin
            name = "unknown";
            report_failure($sformatf("no check defined for test %0d", number));
         end
      endcase
      $display("test %0d %s: %s after %0d cycles", number, name,
               (test_errors == 0) ? "ok" : "failed", cycles);
      error_count <= error_count + test_errors;
      tests_done <= number;
   endtask

   initial
   begin
      tests_done <= 0;
      error_count <= 0;
      @(posedge clock_25mhz);
      while (reset_sync)
         @(posedge clock_25mhz);
      forever
      begin
         @(posedge clock_25mhz);
         if (check_start)
            run_test(tests_done + 1);
      end
   end

endmodule

// File: hdl/car_security_top.sv
`timescale 1ns/100ps

module car_security_top
#(
   parameter int DEBOUNCE_CYCLES = 250000,
   parameter int TICK_CYCLES = 25000000
)
(
   input  logic       clock_25mhz,
   input  logic       reset_sync,
   input  logic       ignition,
   input  logic       driver_door,
   input  logic       passenger_door,
   input  logic       hidden_switch,
   input  logic       brake,
   input  logic       reprogram,
   input  logic [1:0] time_selector,
   input  logic [3:0] time_value,
   output logic       alarm,
   output logic       status_led,
   output logic       fuel_pump_power
);
   import anti_theft_pkg::*;

   interval_e   time_selector_clean;
   time_value_t time_value_clean;
   interval_e   interval;
   indicator_e  indicator;
   time_value_t delay_value;
   logic        start_timer;
   logic        expired;
   logic        second_tick;

   sensor_if sensors ();

   input_conditioner #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) u_input_conditioner (
      .clock_25mhz       (clock_25mhz),
      .reset_sync        (reset_sync),
      .raw_controls      ({reprogram, brake, hidden_switch,
                           passenger_door, driver_door, ignition}),
      .time_selector_raw (time_selector),
      .time_value_raw    (time_value),
      .sensors           (sensors.conditioner),
      .time_selector     (time_selector_clean),
      .time_value        (time_value_clean)
   );

   ////////////////////////////////////////////////////////////////////////////
   // alarm path
   ////////////////////////////////////////////////////////////////////////////

   anti_theft_fsm u_anti_theft_fsm (
      .clock_25mhz (clock_25mhz),
      .reset_sync  (reset_sync),
      .sensors     (sensors.alarm),
      .expired     (expired),
      .start_timer (start_timer),
      .interval    (interval),
      .indicator   (indicator),
      .alarm       (alarm)
   );

   time_parameters u_time_parameters (
      .clock_25mhz   (clock_25mhz),
      .reset_sync    (reset_sync),
      .reprogram     (sensors.reprogram),
      .time_selector (time_selector_clean),
      .time_value    (time_value_clean),
      .interval      (interval),
      .delay_value   (delay_value)
   );

   countdown_timer #(
      .TICK_CYCLES (TICK_CYCLES)
   ) u_countdown_timer (
      .clock_25mhz (clock_25mhz),
      .reset_sync  (reset_sync),
      .start_timer (start_timer),
      .delay_value (delay_value),
      .second_tick (second_tick),
      .expired     (expired)
   );

   status_light u_status_light (
      .clock_25mhz (clock_25mhz),
      .reset_sync  (reset_sync),
      .indicator   (indicator),
      .second_tick (second_tick),
      .status_led  (status_led)
   );

   // immobilizer, independent of the alarm
   fuel_pump_fsm u_fuel_pump_fsm (
      .clock_25mhz     (clock_25mhz),
      .reset_sync      (reset_sync),
      .sensors         (sensors.fuel),
      .fuel_pump_power (fuel_pump_power)
   );

endmodule

// File: hdl/fuel_pump_fsm.sv
`timescale 1ns/100ps

module fuel_pump_fsm
(
   input  logic    clock_25mhz,
   input  logic    reset_sync,
   sensor_if.fuel  sensors,
   output logic    fuel_pump_power
);
   import anti_theft_pkg::*;

   fuel_state_e state;

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         state <= pump_off;
         fuel_pump_power <= 1'b0;
      end
      else
      begin
         case (state)
            pump_off:
            begin
               fuel_pump_power <= 1'b0;
               if (sensors.ignition)
                  state <= restore_start;
            end
            restore_start:
            begin
               // waits for the hidden switch and brake together
               if (!sensors.ignition)
                  state <= pump_off;
               else if (sensors.hidden_switch && sensors.brake)
                  state <= restore;
            end
            restore:
            begin
               fuel_pump_power <= 1'b1;
               state <= latch_on;
            end
            default:
            begin
               if (!sensors.ignition)
               begin
                  fuel_pump_power <= 1'b0;
                  state <= pump_off;
               end
            end
         endcase
      end
   end

endmodule

// File: hdl/status_light.sv
`timescale 1ns/100ps

module status_light
(
   input  logic                       clock_25mhz,
   input  logic                       reset_sync,
   input  anti_theft_pkg::indicator_e indicator,
   input  logic                       second_tick,
   output logic                       status_led
);
   import anti_theft_pkg::*;

   logic blink_phase;

   // starts dark, flips once a second
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
         blink_phase <= 1'b0;
      else if (second_tick)
         blink_phase <= ~blink_phase;
   end

   always_comb
   begin
      case (indicator)
         indicator_on:       status_led = 1'b1;
         indicator_blinking: status_led = blink_phase;
         default:            status_led = 1'b0;
      endcase
   end

endmodule

// File: anti_theft/countdown_timer.sv
`timescale 1ns/100ps

module countdown_timer
#(
   parameter int TICK_CYCLES = 25000000
)
(
   input  logic                        clock_25mhz,
   input  logic                        reset_sync,
   input  logic                        start_timer,
   input  anti_theft_pkg::time_value_t delay_value,
   output logic                        second_tick,
   output logic                        expired
);
   import anti_theft_pkg::*;

   localparam int TICK_WIDTH = $clog2(TICK_CYCLES);

   logic [TICK_WIDTH-1:0] tick_count;
   time_value_t           seconds;
   logic                  load_pending;
   logic                  running;

   ////////////////////////////////////////////////////////////////////////////
   // one-second tick, restarted by start_timer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync || start_timer)
      begin
         tick_count <= '0;
         second_tick <= 1'b0;
      end
      else if (tick_count == TICK_WIDTH'(TICK_CYCLES - 1))
      begin
         tick_count <= '0;
         second_tick <= 1'b1;
      end
      else
      begin
         tick_count <= tick_count + 1'b1;
         second_tick <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // seconds countdown
   ////////////////////////////////////////////////////////////////////////////

   // delay_value trails interval by a cycle, so the load waits one cycle
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         load_pending <= 1'b0;
         running <= 1'b0;
         expired <= 1'b0;
      end
      else
      begin
         load_pending <= start_timer;
         expired <= 1'b0;
         if (start_timer)
            running <= 1'b0;
         else if (load_pending)
            running <= 1'b1;
         else if (running && second_tick && seconds == '0)
         begin
            expired <= 1'b1;
            running <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock_25mhz)
   begin
      if (load_pending)
         seconds <= delay_value;
      else if (running && second_tick && seconds != '0)
         seconds <= seconds - 1'b1;
   end

   expired_single_cycle: assert property (
      @(posedge clock_25mhz) disable iff (reset_sync)
      expired |=> !expired
   );

endmodule

// File: anti_theft/time_parameters.sv
`timescale 1ns/100ps

module time_parameters
(
   input  logic                        clock_25mhz,
   input  logic                        reset_sync,
   input  logic                        reprogram,
   input  anti_theft_pkg::interval_e   time_selector,
   input  anti_theft_pkg::time_value_t time_value,
   input  anti_theft_pkg::interval_e   interval,
   output anti_theft_pkg::time_value_t delay_value
);
   import anti_theft_pkg::*;

   time_value_t delays [4];

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         delays[interval_arm_delay] <= DEFAULT_ARM_DELAY;
         delays[interval_driver_delay] <= DEFAULT_DRIVER_DELAY;
         delays[interval_passenger_delay] <= DEFAULT_PASSENGER_DELAY;
         delays[interval_alarm_on] <= DEFAULT_ALARM_ON;
      end
      else if (reprogram)
      begin
         delays[time_selector] <= time_value;
      end
   end

   // selected delay, frozen while reprogramming
   always_ff @(posedge clock_25mhz)
   begin
      if (!reprogram)
      begin
         delay_value <= delays[interval];
      end
   end

endmodule

// File: anti_theft/anti_theft_fsm.sv
`timescale 1ns/100ps

module anti_theft_fsm
(
   input  logic                       clock_25mhz,
   input  logic                       reset_sync,
   sensor_if.alarm                    sensors,
   input  logic                       expired,
   output logic                       start_timer,
   output anti_theft_pkg::interval_e  interval,
   output anti_theft_pkg::indicator_e indicator,
   output logic                       alarm
);
   import anti_theft_pkg::*;

   alarm_state_e state;
   alarm_state_e state_next;
   logic         start_next;
   interval_e    interval_next;
   logic         any_door;

   assign any_door = sensors.driver_door | sensors.passenger_door;

   ////////////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_next = state;
      start_next = 1'b0;
      interval_next = interval;
      case (state)
         armed:
         begin
            if (sensors.ignition)
               state_next = disarmed;
            else if (sensors.driver_door)
            begin
               state_next = triggered;
               start_next = 1'b1;
               interval_next = interval_driver_delay;
            end
            else if (sensors.passenger_door)
            begin
               state_next = triggered;
               start_next = 1'b1;
               interval_next = interval_passenger_delay;
            end
         end
         triggered:
         begin
            if (sensors.ignition)
               state_next = disarmed;
            else if (expired)
               state_next = sound_alarm;
         end
         sound_alarm:
         begin
            if (sensors.ignition)
               state_next = disarmed;
            else if (!any_door)
            begin
               // alarm keeps going for the alarm-on time once all doors are shut
               state_next = expiring_alarm;
               start_next = 1'b1;
               interval_next = interval_alarm_on;
            end
         end
         expiring_alarm:
         begin
            if (sensors.ignition)
               state_next = disarmed;
            else if (expired)
               state_next = armed;
            else if (any_door)
               state_next = sound_alarm;
         end
         disarmed:
         begin
            if (!sensors.ignition)
               state_next = disarmed_wait_door;
         end
         disarmed_wait_door:
         begin
            if (sensors.ignition)
               state_next = disarmed;
            else if (sensors.driver_door)
               state_next = disarmed_door_open;
         end
         disarmed_door_open:
         begin
            if (sensors.ignition)
               state_next = disarmed;
            else if (!sensors.driver_door)
            begin
               state_next = disarmed_arming;
               start_next = 1'b1;
               interval_next = interval_arm_delay;
            end
         end
         disarmed_arming:
         begin
            // any activity during the arm delay cancels arming
            if (sensors.ignition || any_door)
               state_next = disarmed;
            else if (expired)
               state_next = armed;
         end
         default:
         begin
            state_next = armed;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // state and output registers
   ////////////////////////////////////////////////////////////////////////////

   // outputs follow the next state so they change together with it
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync || sensors.reprogram)
      begin
         state <= armed;
         start_timer <= 1'b0;
         interval <= interval_arm_delay;
         indicator <= indicator_blinking;
         alarm <= 1'b0;
      end
      else
      begin
         state <= state_next;
         start_timer <= start_next;
         interval <= interval_next;
         alarm <= (state_next == sound_alarm) || (state_next == expiring_alarm);
         if (state_next == armed)
            indicator <= indicator_blinking;
         else if (state_next inside {triggered, sound_alarm, expiring_alarm})
            indicator <= indicator_on;
         else
            indicator <= indicator_off;
      end
   end

   start_single_cycle: assert property (
      @(posedge clock_25mhz) disable iff (reset_sync)
      start_timer |=> !start_timer
   );

   // ignition disarms from every state and leaves the alarm quiet
   ignition_silences_alarm: assert property (
      @(posedge clock_25mhz) disable iff (reset_sync)
      (sensors.ignition && !sensors.reprogram) |=> (state == disarmed) && !alarm
   );

endmodule

// File: hdl/input_conditioner.sv
`timescale 1ns/100ps

module input_conditioner
#(
   parameter int DEBOUNCE_CYCLES = 250000
)
(
   input  logic                                      clock_25mhz,
   input  logic                                      reset_sync,
   input  logic [anti_theft_pkg::NUM_CONTROLS-1:0]   raw_controls,
   input  logic [anti_theft_pkg::INTERVAL_WIDTH-1:0] time_selector_raw,
   input  anti_theft_pkg::time_value_t               time_value_raw,
   sensor_if.conditioner                             sensors,
   output anti_theft_pkg::interval_e                 time_selector,
   output anti_theft_pkg::time_value_t               time_value
);
   import anti_theft_pkg::*;

   localparam int NUM_BITS = NUM_CONTROLS + INTERVAL_WIDTH + TIME_VALUE_WIDTH;
   localparam int COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

   logic [NUM_BITS-1:0]    raw_bits;
   logic [NUM_BITS-1:0]    last_bits;
   logic [NUM_BITS-1:0]    clean_bits;
   logic [COUNT_WIDTH-1:0] settle_count [NUM_BITS];

   assign raw_bits = {time_value_raw, time_selector_raw, raw_controls};

   // one settle counter per bit, restarted on every raw change
   always_ff @(posedge clock_25mhz)
   begin
      for (int i = 0; i < NUM_BITS; i++)
      begin
         if (reset_sync)
         begin
            last_bits[i] <= raw_bits[i];
            clean_bits[i] <= raw_bits[i];
            settle_count[i] <= '0;
         end
         else if (raw_bits[i] != last_bits[i])
         begin
            last_bits[i] <= raw_bits[i];
            settle_count[i] <= '0;
         end
         else if (settle_count[i] == COUNT_WIDTH'(DEBOUNCE_CYCLES))
         begin
            clean_bits[i] <= last_bits[i];
         end
         else
         begin
            settle_count[i] <= settle_count[i] + 1'b1;
         end
      end
   end

   assign sensors.ignition       = clean_bits[0];
   assign sensors.driver_door    = clean_bits[1];
   assign sensors.passenger_door = clean_bits[2];
   assign sensors.hidden_switch  = clean_bits[3];
   assign sensors.brake          = clean_bits[4];
   assign sensors.reprogram      = clean_bits[5];

   assign time_selector = interval_e'(clean_bits[NUM_CONTROLS +: INTERVAL_WIDTH]);
   assign time_value    = clean_bits[NUM_BITS-1 -: TIME_VALUE_WIDTH];

endmodule

// File: common/sensor_if.sv
`timescale 1ns/100ps

interface sensor_if;

   // debounced driver controls, all levels
   logic ignition;
   logic driver_door;
   logic passenger_door;
   logic hidden_switch;
   logic brake;
   logic reprogram;

   modport conditioner (
      output ignition, driver_door, passenger_door,
      output hidden_switch, brake, reprogram
   );

   modport alarm (input ignition, driver_door, passenger_door, reprogram);

   modport fuel (input ignition, hidden_switch, brake);

endinterface

// File: common/anti_theft_pkg.sv
package anti_theft_pkg;

   localparam int NUM_CONTROLS = 6;
   localparam int INTERVAL_WIDTH = 2;
   localparam int TIME_VALUE_WIDTH = 4;

   typedef logic [TIME_VALUE_WIDTH-1:0] time_value_t;

   // index into the delay registers
   typedef enum logic [INTERVAL_WIDTH-1:0] {
      interval_arm_delay       = 2'd0,
      interval_driver_delay    = 2'd1,
      interval_passenger_delay = 2'd2,
      interval_alarm_on        = 2'd3
   } interval_e;

   typedef enum logic [1:0] {
      indicator_off      = 2'd0,
      indicator_blinking = 2'd1,
      indicator_on       = 2'd2
   } indicator_e;

   typedef enum logic [2:0] {
      armed              = 3'd0,
      triggered          = 3'd1,
      sound_alarm        = 3'd2,
      expiring_alarm     = 3'd3,
      disarmed           = 3'd4,
      disarmed_wait_door = 3'd5,
      disarmed_door_open = 3'd6,
      disarmed_arming    = 3'd7
   } alarm_state_e;

   typedef enum logic [1:0] {
      pump_off      = 2'd0,
      restore_start = 2'd1,
      restore       = 2'd2,
      latch_on      = 2'd3
   } fuel_state_e;

   // delays in seconds after reset
   localparam time_value_t DEFAULT_ARM_DELAY       = 4'd6;
   localparam time_value_t DEFAULT_DRIVER_DELAY    = 4'd8;
   localparam time_value_t DEFAULT_PASSENGER_DELAY = 4'd15;
   localparam time_value_t DEFAULT_ALARM_ON        = 4'd10;

endpackage
